//--- dv/mem_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mem_checker #(
	parameter int mem_words = 1024
) (
	input logic clk,
	input logic rst,
	input mem_pkg::mem_req_t req_data,
	input logic ack,
	input logic rsp_req,
	input mem_pkg::mem_rsp_t rsp_data,
	input int test_num,
	output int mismatches,
	output int protocol_errors,
	output int pending
);
	import mem_pkg::*;

	mem_lanes_t model [mem_words];
	mem_req_t req_q [$];
	int test_q [$];
	logic ack_d;
	logic rsp_req_d;
	mem_req_t cur_req;
	int cur_test;
	mem_rsp_t expected;

	initial begin
		for (int i = 0; i < mem_words; i++) begin
			model[i] = '0;
		end
		ack_d = 1'b0;
		rsp_req_d = 1'b0;
		mismatches = 0;
		protocol_errors = 0;
		pending = 0;
	end

	function automatic string test_name(input int n);
		case (n)
			1: return "reset_and_zero_reads";
			2: return "full_write_read";
			3: return "partial_strobes";
			4: return "bad_addresses";
			5: return "back_to_back_slow_ack";
			6: return "random_mix";
			default: return "unknown";
		endcase
	endfunction

	// expected response, and the model updated the way the memory should be.
	function automatic mem_rsp_t ref_access(input mem_req_t r);
		mem_lanes_t old_word;
		mem_lanes_t new_word;
		int idx;
		idx = int'(r.addr) / bytes_per_word;
		if ((int'(r.addr) % bytes_per_word) != 0 || idx >= mem_words) begin
			return '{rdata: '0, err: 1'b1};
		end
		old_word = model[idx];
		new_word.word = r.wdata;
		if (r.write) begin
			for (int i = 0; i < bytes_per_word; i++) begin
				if (r.strobe[i]) model[idx].lanes[i] = new_word.lanes[i];
			end
		end
		return '{rdata: old_word.word, err: 1'b0}; // read-first, so writes return the old word.
	endfunction

	// --------------------------------------------------
	// link monitor
	// --------------------------------------------------
	always @(negedge clk) begin
		if (rst) begin
			if (ack !== 1'b0 || rsp_req !== 1'b0) begin
				$display("ack or rsp_req is not low during reset");
				protocol_errors = protocol_errors + 1;
			end
		end else begin
			if (ack && !ack_d) begin
				req_q.push_back(req_data);
				test_q.push_back(test_num);
			end
			if (rsp_req && !rsp_req_d) begin
				if (req_q.size() == 0) begin
					$display("a response arrived with no request outstanding");
					protocol_errors = protocol_errors + 1;
				end else begin
					cur_req = req_q.pop_front();
					cur_test = test_q.pop_front();
					expected = ref_access(cur_req);
					if (rsp_data !== expected) begin
						$display("MISMATCH %s addr=%h: expected rdata=%h err=%b, actual rdata=%h err=%b",
							test_name(cur_test), cur_req.addr, expected.rdata, expected.err,
							rsp_data.rdata, rsp_data.err);
						mismatches = mismatches + 1;
					end
				end
			end
		end
		ack_d = ack;
		rsp_req_d = rsp_req;
		pending = req_q.size();
	end

endmodule

`default_nettype wire

//--- dv/mem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_tb;
	import mem_pkg::*;

	localparam int mem_words = 1024;
	localparam int read_latency = 1;
	localparam int num_transactions = 200; // a little above the count sent below.
	localparam int max_cycles = num_transactions * 40;

	logic clk = 1'b0;
	logic rst;
	logic req;
	mem_req_t req_data;
	logic ack;
	logic rsp_req;
	mem_rsp_t rsp_data;
	logic rsp_ack;

	int seed = 18;
	int test_num = 0;
	int cycle_count = 0;
	int ack_delay;
	int drain;
	int mismatches;
	int protocol_errors;
	int pending;
	logic use_gaps;
	logic slow_ack;
	logic [31:0] r;
	mem_addr_t a;

	always #2 clk = ~clk;

	mem_subsystem #(
		.mem_words(mem_words),
		.read_latency(read_latency)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_data(req_data),
		.ack(ack),
		.rsp_req(rsp_req),
		.rsp_data(rsp_data),
		.rsp_ack(rsp_ack)
	);

	mem_checker #(
		.mem_words(mem_words)
	) chk_i (
		.clk(clk),
		.rst(rst),
		.req_data(req_data),
		.ack(ack),
		.rsp_req(rsp_req),
		.rsp_data(rsp_data),
		.test_num(test_num),
		.mismatches(mismatches),
		.protocol_errors(protocol_errors),
		.pending(pending)
	);

	task automatic report_counts();
		$display("errors: %0d mismatches, %0d protocol errors, %0d unanswered requests",
			mismatches, protocol_errors, pending);
	endtask

	// one four-phase request, started on a rising edge after an optional gap.
	task automatic send_req(input mem_addr_t addr, input logic write, input mem_strobe_t strobe,
			input mem_word_t wdata);
		int gap;
		gap = use_gaps ? ($random(seed) & 3) : 0;
		repeat (gap) @(posedge clk);
		req_data <= '{addr: addr, write: write, strobe: strobe, wdata: wdata};
		req <= 1'b1;
		do @(negedge clk); while (!ack);
		@(posedge clk);
		req <= 1'b0;
		do @(negedge clk); while (ack);
		@(posedge clk);
	endtask

	// --------------------------------------------------
	// response acceptor
	// --------------------------------------------------
	always begin
		@(negedge clk);
		if (rsp_req && !rsp_ack) begin
			ack_delay = $random(seed) & 7;
			if (slow_ack) ack_delay = ack_delay | 4;
			repeat (ack_delay) @(posedge clk);
			@(posedge clk);
			rsp_ack <= 1'b1;
			do @(negedge clk); while (rsp_req);
			@(posedge clk);
			rsp_ack <= 1'b0;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == max_cycles) begin
			$display("timeout after %0d cycles, the run did not finish", max_cycles);
			report_counts();
			$display("Some tests failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		rst = 1'b1;
		req = 1'b0;
		req_data = '0;
		rsp_ack = 1'b0;
		use_gaps = 1'b1;
		slow_ack = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		test_num = 1;
		for (int i = 0; i < 4; i++) send_req(16'(i * 64), 1'b0, 4'h0, 32'h0);

		test_num = 2;
		send_req(16'h0040, 1'b1, 4'hF, 32'hDEADBEEF);
		send_req(16'h0040, 1'b0, 4'h0, 32'h0);
		send_req(16'h0040, 1'b1, 4'hF, 32'h12345678); // must hand back the first word.
		send_req(16'h0040, 1'b0, 4'h0, 32'h0);

		test_num = 3;
		send_req(16'h0080, 1'b1, 4'hF, 32'h11223344);
		send_req(16'h0080, 1'b1, 4'b0101, 32'hAABBCCDD);
		send_req(16'h0080, 1'b0, 4'h0, 32'h0);
		send_req(16'h0080, 1'b1, 4'b1000, 32'hEE000000);
		send_req(16'h0080, 1'b0, 4'h0, 32'h0);

		test_num = 4;
		send_req(16'h0100, 1'b1, 4'hF, 32'hCAFEF00D);
		send_req(16'h0101, 1'b0, 4'h0, 32'h0);
		send_req(16'h0102, 1'b1, 4'hF, 32'h55555555);
		send_req(16'(mem_words * bytes_per_word), 1'b0, 4'h0, 32'h0);
		send_req(16'(mem_words * bytes_per_word), 1'b1, 4'hF, 32'h66666666);
		send_req(16'hFFFC, 1'b1, 4'hF, 32'h77777777);
		send_req(16'h0100, 1'b0, 4'h0, 32'h0);
		send_req(16'h0104, 1'b0, 4'h0, 32'h0);
		// the words a truncated out-of-range index would land on.
		send_req(16'h0000, 1'b0, 4'h0, 32'h0);
		send_req(16'((mem_words - 1) * bytes_per_word), 1'b0, 4'h0, 32'h0);

		test_num = 5;
		use_gaps = 1'b0;
		slow_ack = 1'b1;
		for (int i = 0; i < 20; i++) begin
			send_req(16'(16'h0200 + 4 * (i % 5)), i[0], 4'hF, 32'(32'hA5000000 + i));
		end

		test_num = 6;
		use_gaps = 1'b1;
		slow_ack = 1'b0;
		for (int i = 0; i < 150; i++) begin
			r = $random(seed);
			a = {10'd0, r[5:2], 2'b00};
			if (r[10:8] == 3'd0) a[1:0] = r[12:11]; // now and then a misaligned one.
			if (r[10:8] == 3'd1) a = a + 16'h1000;
			send_req(a, r[21], r[20:17], $random(seed));
		end

		drain = 0;
		while (pending != 0 && drain < 200) begin
			@(posedge clk);
			drain++;
		end
		if (pending != 0) $display("%0d requests were never answered", pending);
		report_counts();
		if (mismatches == 0 && protocol_errors == 0 && pending == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/access_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module access_sequencer #(
	parameter int mem_words = 1024,
	parameter int read_latency = 1
) (
	input logic clk,
	input logic rst,

	// command from the receiver.
	input logic cmd_valid,
	input mem_pkg::mem_cmd_t cmd,
	output logic cmd_take,

	// response toward the sender.
	output logic rsp_load,
	output mem_pkg::mem_rsp_t rsp_in,
	input logic sender_busy
);
	import mem_pkg::*;

	localparam int ram_addr_bits = $clog2(mem_words);

	typedef enum logic [1:0] {
		st_idle,
		st_access,
		st_wait,
		st_offer
	} state_t;

	state_t state;
	mem_cmd_t cmd_q;
	mem_rsp_t rsp_q;
	logic [1:0] lat_cnt;
	logic resp_ready;

	logic ram_en;
	logic [ram_addr_bits-1:0] ram_addr;
	mem_strobe_t ram_strobe;
	mem_lanes_t ram_wdata;
	mem_word_t ram_rdata;

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	assign cmd_take = (state == st_idle) && cmd_valid;
	assign resp_ready = (state == st_wait) && (lat_cnt == 2'(read_latency));
	assign rsp_load = ((state == st_offer) || resp_ready) && !sender_busy;

	// the word leaves straight from the RAM when the sender is free, otherwise from rsp_q.
	assign rsp_in = (state == st_offer) ? rsp_q : '{rdata: ram_rdata, err: 1'b0};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			lat_cnt <= 2'd0;
		end else begin
			case (state)
				st_idle: begin
					if (cmd_take) begin
						state <= cmd.err ? st_offer : st_access;
					end
				end
				st_access: begin
					state <= st_wait;
					lat_cnt <= 2'd1;
				end
				st_wait: begin
					if (resp_ready) begin
						state <= sender_busy ? st_offer : st_idle;
					end else begin
						lat_cnt <= lat_cnt + 2'd1;
					end
				end
				st_offer: begin
					if (!sender_busy) state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// --------------------------------------------------
	// payload
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (cmd_take) begin
			cmd_q <= cmd;
			if (cmd.err) rsp_q <= '{rdata: '0, err: 1'b1}; // no RAM access for a bad address.
		end else if (resp_ready && sender_busy) begin
			rsp_q <= '{rdata: ram_rdata, err: 1'b0};
		end
	end

	// the RAM is read-first, so a write also hands back the old word.
	assign ram_en = (state == st_access);
	assign ram_addr = cmd_q.index[ram_addr_bits-1:0];
	assign ram_strobe = cmd_q.write ? cmd_q.strobe : '0;
	assign ram_wdata.word = cmd_q.wdata;

	ram_single_port #(
		.mem_words(mem_words),
		.read_latency(read_latency)
	) ram_i (
		.clk(clk),
		.en(ram_en),
		.addr(ram_addr),
		.strobe(ram_strobe),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

endmodule

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int data_width = 32;
	localparam int byte_width = 8;
	localparam int bytes_per_word = data_width / byte_width;
	localparam int addr_width = 16;
	localparam int word_idx_width = addr_width - $clog2(bytes_per_word);

	typedef logic [addr_width-1:0] mem_addr_t;
	typedef logic [data_width-1:0] mem_word_t;
	typedef logic [bytes_per_word-1:0] mem_strobe_t;
	typedef logic [byte_width-1:0] mem_byte_t;
	typedef logic [word_idx_width-1:0] mem_idx_t; // word index taken from a byte address.

	// one word seen either whole or as byte lanes, lane 0 in the low bits.
	typedef union packed {
		mem_word_t word;
		mem_byte_t [bytes_per_word-1:0] lanes;
	} mem_lanes_t;

	// --------------------------------------------------
	// link payloads
	// --------------------------------------------------
	typedef struct packed {
		mem_addr_t addr;
		logic write;
		mem_strobe_t strobe;
		mem_word_t wdata;
	} mem_req_t;

	typedef struct packed {
		mem_word_t rdata;
		logic err; // set for a misaligned or out-of-range address.
	} mem_rsp_t;

	// a checked request as it leaves the receiver.
	typedef struct packed {
		mem_addr_t addr;
		logic write;
		mem_strobe_t strobe;
		mem_word_t wdata;
		mem_idx_t index;
		logic err;
	} mem_cmd_t;

endpackage

`default_nettype wire

//--- logic/mem_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsystem #(
	parameter int mem_words = 1024,
	parameter int read_latency = 1 // 1 to 3.
) (
	input logic clk,
	input logic rst,

	input logic req,
	input mem_pkg::mem_req_t req_data,
	output logic ack,

	output logic rsp_req,
	output mem_pkg::mem_rsp_t rsp_data,
	input logic rsp_ack
);
	import mem_pkg::*;

	logic cmd_valid;
	logic cmd_take;
	mem_cmd_t cmd;

	logic rsp_load;
	logic sender_busy;
	mem_rsp_t rsp_in;

	// --------------------------------------------------
	// input side
	// --------------------------------------------------
	req_receiver #(
		.mem_words(mem_words)
	) rx_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_data(req_data),
		.ack(ack),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_take(cmd_take)
	);

	// sequencer and RAM.
	access_sequencer #(
		.mem_words(mem_words),
		.read_latency(read_latency)
	) seq_i (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_take(cmd_take),
		.rsp_load(rsp_load),
		.rsp_in(rsp_in),
		.sender_busy(sender_busy)
	);

	// --------------------------------------------------
	// output side
	// --------------------------------------------------
	rsp_sender tx_i (
		.clk(clk),
		.rst(rst),
		.rsp_load(rsp_load),
		.rsp_in(rsp_in),
		.sender_busy(sender_busy),
		.rsp_req(rsp_req),
		.rsp_data(rsp_data),
		.rsp_ack(rsp_ack)
	);

endmodule

`default_nettype wire

//--- logic/ram_single_port.sv
`timescale 1ns/100ps
`default_nettype none

module ram_single_port #(
	parameter int mem_words = 1024,
	parameter int read_latency = 1,
	localparam int addr_bits = $clog2(mem_words)
) (
	input logic clk,
	input logic en,
	input logic [addr_bits-1:0] addr,
	input mem_pkg::mem_strobe_t strobe,
	input mem_pkg::mem_lanes_t wdata,
	output mem_pkg::mem_word_t rdata
);
	import mem_pkg::*;

	mem_lanes_t mem [mem_words];
	mem_word_t pipe [read_latency];

	// contents start out as zero.
	initial begin
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = '0;
		end
	end

	// --------------------------------------------------
	// array, read-first
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (en) begin
			pipe[0] <= mem[addr].word; // the old word is sampled before the write lands.
			for (int i = 0; i < bytes_per_word; i++) begin
				if (strobe[i]) mem[addr].lanes[i] <= wdata.lanes[i];
			end
		end
		// extra output stages when more than one cycle of latency is asked for.
		for (int s = 1; s < read_latency; s++) begin
			pipe[s] <= pipe[s-1];
		end
	end

	assign rdata = pipe[read_latency-1];

endmodule

`default_nettype wire

//--- logic/req_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module req_receiver #(
	parameter int mem_words = 1024
) (
	input logic clk,
	input logic rst,

	// request link from the host.
	input logic req,
	input mem_pkg::mem_req_t req_data,
	output logic ack,

	// holding register toward the sequencer.
	output logic cmd_valid,
	output mem_pkg::mem_cmd_t cmd,
	input logic cmd_take
);
	import mem_pkg::*;

	localparam int offset_bits = $clog2(bytes_per_word);

	mem_idx_t word_index;
	logic misaligned;
	logic out_of_range;
	logic accept;

	// --------------------------------------------------
	// address check
	// --------------------------------------------------
	assign word_index = req_data.addr[addr_width-1:offset_bits];
	assign misaligned = |req_data.addr[offset_bits-1:0]; // byte offset must be zero.
	assign out_of_range = 32'(word_index) >= mem_words;

	// a new request is only taken once the last one has left the holding register
	// and the previous handshake has fully closed.
	assign accept = req && !ack && !cmd_valid;

	// --------------------------------------------------
	// four-phase receive side
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
		end else if (accept) begin
			ack <= 1'b1;
		end else if (ack && !req) begin
			ack <= 1'b0; // host has seen ack and released req.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_valid <= 1'b0;
		end else if (cmd_take) begin
			cmd_valid <= 1'b0;
		end else if (accept) begin
			cmd_valid <= 1'b1;
		end
	end

	// holding register, loaded on the same edge that raises ack.
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd <= '{
				addr: req_data.addr,
				write: req_data.write,
				strobe: req_data.strobe,
				wdata: req_data.wdata,
				index: word_index,
				err: misaligned || out_of_range
			};
		end
	end

endmodule

`default_nettype wire

//--- logic/rsp_sender.sv
`timescale 1ns/100ps
`default_nettype none

module rsp_sender (
	input logic clk,
	input logic rst,

	// response from the sequencer.
	input logic rsp_load,
	input mem_pkg::mem_rsp_t rsp_in,
	output logic sender_busy,

	// response link to the host.
	output logic rsp_req,
	output mem_pkg::mem_rsp_t rsp_data,
	input logic rsp_ack
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_drop
	} state_t;

	state_t state;

	// --------------------------------------------------
	// four-phase send side
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (rsp_load) state <= st_request;
				end
				st_request: begin
					if (rsp_ack) state <= st_drop; // host has the data, release rsp_req.
				end
				st_drop: begin
					if (!rsp_ack) state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// output register, held for the whole handshake.
	always_ff @(posedge clk) begin
		if (rsp_load && (state == st_idle)) begin
			rsp_data <= rsp_in;
		end
	end

	assign rsp_req = (state == st_request);

	// busy until the host has also dropped its ack.
	assign sender_busy = (state != st_idle);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module mem_tb -f src.f -o mem_sim > build.log 2>&1 \
	&& ./obj_dir/mem_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- src.f
logic/mem_pkg.sv
logic/ram_single_port.sv
logic/req_receiver.sv
logic/access_sequencer.sv
logic/rsp_sender.sv
logic/mem_subsystem.sv
dv/mem_checker.sv
dv/mem_tb.sv
